/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath geometry
`define CORE_DATA_W     32
`define CORE_REG_AW     5
`define CORE_REG_COUNT  32

// Primary opcodes
`define CORE_OP_RTYPE   6'h00
`define CORE_OP_ADDIU   6'h09
`define CORE_OP_ANDI    6'h0c
`define CORE_OP_ORI     6'h0d
`define CORE_OP_LUI     6'h0f

// R-type function codes
`define CORE_FN_SLL     6'h00
`define CORE_FN_SRL     6'h02
`define CORE_FN_SRA     6'h03
`define CORE_FN_SLLV    6'h04
`define CORE_FN_ADDU    6'h21
`define CORE_FN_SUBU    6'h23
`define CORE_FN_AND     6'h24
`define CORE_FN_OR      6'h25
`define CORE_FN_XOR     6'h26
`define CORE_FN_SLT     6'h2a

// Cycles from instruction in to write-back out
`define CORE_LATENCY    3

`endif

/* logic/core_pkg.sv */
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_DATA_W-1:0] word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    ////////////////////
    // Instruction formats

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // Opcode picks the view of the same word
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    ////////////////////
    // Execute operations

    typedef enum logic [3:0] {
        exe_add,
        exe_sub,
        exe_and,
        exe_or,
        exe_xor,
        exe_slt,
        exe_sll,
        exe_srl,
        exe_sra
    } exe_op_e;

endpackage

`default_nettype wire

/* logic/core_ifs.sv */
`default_nettype none

// Decoded bundle from decode to execute
interface dec_exe_if import core_pkg::*; ();
    logic       valid;
    exe_op_e    op;
    word_t      a_data;
    word_t      b_data;
    reg_addr_t  a_addr;
    reg_addr_t  b_addr;
    logic       shamt_from_reg;
    logic [4:0] shamt;
    reg_addr_t  dest;

    modport source (
        output valid, op, a_data, b_data, a_addr, b_addr,
        output shamt_from_reg, shamt, dest
    );

    modport sink (
        input valid, op, a_data, b_data, a_addr, b_addr,
        input shamt_from_reg, shamt, dest
    );
endinterface

// Executed result from execute to result
interface exe_res_if import core_pkg::*; ();
    logic      valid;
    reg_addr_t dest;
    word_t     data;

    modport source (
        output valid, dest, data
    );

    modport sink (
        input valid, dest, data
    );
endinterface

// Operand read answered combinationally
interface reg_read_if import core_pkg::*; ();
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    modport requester (
        output rs_addr, rt_addr,
        input  rs_data, rt_data
    );

    modport responder (
        input  rs_addr, rt_addr,
        output rs_data, rt_data
    );
endinterface

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

`include "core_settings.svh"

module decode_stage import core_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          instr_valid_i,
    input  instr_u        instr_i,
    reg_read_if.requester rd_port,
    dec_exe_if.source     dec_o
);

    logic       supported;
    exe_op_e    op_d;
    word_t      a_data_d;
    word_t      b_data_d;
    reg_addr_t  a_addr_d;
    reg_addr_t  b_addr_d;
    reg_addr_t  dest_d;
    logic       shamt_from_reg_d;
    word_t      imm_sext;
    word_t      imm_zext;

    logic       valid_q;
    exe_op_e    op_q;
    word_t      a_data_q;
    word_t      b_data_q;
    reg_addr_t  a_addr_q;
    reg_addr_t  b_addr_q;
    logic       shamt_from_reg_q;
    logic [4:0] shamt_q;
    reg_addr_t  dest_q;

    assign rd_port.rs_addr = instr_i.r.rs;
    assign rd_port.rt_addr = instr_i.r.rt;

    assign imm_sext = {{(`CORE_DATA_W-16){instr_i.i.imm[15]}}, instr_i.i.imm};
    assign imm_zext = {{(`CORE_DATA_W-16){1'b0}}, instr_i.i.imm};

    ////////////////////
    // Instruction decode

    always_comb begin
        supported        = 1'b1;
        op_d             = exe_add;
        a_data_d         = rd_port.rs_data;
        b_data_d         = rd_port.rt_data;
        a_addr_d         = instr_i.r.rs;
        b_addr_d         = instr_i.r.rt;
        dest_d           = instr_i.r.rd;
        shamt_from_reg_d = 1'b0;

        case (instr_i.r.opcode)
            `CORE_OP_RTYPE: begin
                case (instr_i.r.funct)
                    `CORE_FN_ADDU: op_d = exe_add;
                    `CORE_FN_SUBU: op_d = exe_sub;
                    `CORE_FN_AND:  op_d = exe_and;
                    `CORE_FN_OR:   op_d = exe_or;
                    `CORE_FN_XOR:  op_d = exe_xor;
                    `CORE_FN_SLT:  op_d = exe_slt;
                    `CORE_FN_SLL:  op_d = exe_sll;
                    `CORE_FN_SRL:  op_d = exe_srl;
                    `CORE_FN_SRA:  op_d = exe_sra;
                    `CORE_FN_SLLV: begin
                        op_d             = exe_sll;
                        shamt_from_reg_d = 1'b1;
                    end
                    default:       supported = 1'b0;
                endcase
                // Immediate shifts leave rs unused
                if (op_d inside {exe_sll, exe_srl, exe_sra} && !shamt_from_reg_d) begin
                    a_data_d = '0;
                    a_addr_d = '0;
                end
            end
            `CORE_OP_ADDIU, `CORE_OP_ANDI, `CORE_OP_ORI: begin
                b_addr_d = '0;
                dest_d   = instr_i.i.rt;
                if (instr_i.i.opcode == `CORE_OP_ADDIU) begin
                    b_data_d = imm_sext;
                end else begin
                    op_d     = (instr_i.i.opcode == `CORE_OP_ANDI) ? exe_and : exe_or;
                    b_data_d = imm_zext;
                end
            end
            `CORE_OP_LUI: begin
                // OR of zero with the upper-half immediate
                op_d     = exe_or;
                a_data_d = '0;
                a_addr_d = '0;
                b_data_d = {instr_i.i.imm, {(`CORE_DATA_W-16){1'b0}}};
                b_addr_d = '0;
                dest_d   = instr_i.i.rt;
            end
            default: supported = 1'b0;
        endcase
    end

    ////////////////////
    // Bundle register

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i && supported;
        end
    end

    always_ff @(posedge clk) begin
        op_q             <= op_d;
        a_data_q         <= a_data_d;
        b_data_q         <= b_data_d;
        a_addr_q         <= a_addr_d;
        b_addr_q         <= b_addr_d;
        shamt_from_reg_q <= shamt_from_reg_d;
        shamt_q          <= instr_i.r.shamt;
        dest_q           <= dest_d;
    end

    assign dec_o.valid          = valid_q;
    assign dec_o.op             = op_q;
    assign dec_o.a_data         = a_data_q;
    assign dec_o.b_data         = b_data_q;
    assign dec_o.a_addr         = a_addr_q;
    assign dec_o.b_addr         = b_addr_q;
    assign dec_o.shamt_from_reg = shamt_from_reg_q;
    assign dec_o.shamt          = shamt_q;
    assign dec_o.dest           = dest_q;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    dec_exe_if.sink   dec_i,
    exe_res_if.source res_o
);

    logic       res_valid_q;
    reg_addr_t  res_dest_q;
    word_t      res_data_q;

    logic       fwd_a;
    logic       fwd_b;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shift_amt;
    word_t      alu_out;
    word_t      shift_out;
    word_t      result;

    ////////////////////
    // Forwarding

    // Own output register holds the instruction one ahead
    assign fwd_a = res_valid_q && (res_dest_q != '0) && (res_dest_q == dec_i.a_addr);
    assign fwd_b = res_valid_q && (res_dest_q != '0) && (res_dest_q == dec_i.b_addr);

    assign op_a = fwd_a ? res_data_q : dec_i.a_data;
    assign op_b = fwd_b ? res_data_q : dec_i.b_data;

    ////////////////////
    // ALU and shifter

    assign shift_amt = dec_i.shamt_from_reg ? op_a[4:0] : dec_i.shamt;

    always_comb begin
        case (dec_i.op)
            exe_add: alu_out = op_a + op_b;
            exe_sub: alu_out = op_a - op_b;
            exe_and: alu_out = op_a & op_b;
            exe_or:  alu_out = op_a | op_b;
            exe_xor: alu_out = op_a ^ op_b;
            exe_slt: alu_out = word_t'($signed(op_a) < $signed(op_b));
            default: alu_out = '0;
        endcase
    end

    // Shifted value is always operand B
    always_comb begin
        case (dec_i.op)
            exe_sll: shift_out = op_b << shift_amt;
            exe_srl: shift_out = op_b >> shift_amt;
            exe_sra: shift_out = word_t'($signed(op_b) >>> shift_amt);
            default: shift_out = '0;
        endcase
    end

    assign result = (dec_i.op inside {exe_sll, exe_srl, exe_sra}) ? shift_out : alu_out;

    ////////////////////
    // Result register

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_dest_q <= dec_i.dest;
        res_data_q <= result;
    end

    assign res_o.valid = res_valid_q;
    assign res_o.dest  = res_dest_q;
    assign res_o.data  = res_data_q;

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`default_nettype none

`include "core_settings.svh"

module result_stage import core_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,
    exe_res_if.sink       res_i,
    reg_read_if.responder rd_port,
    output logic          wb_valid_o,
    output reg_addr_t     wb_addr_o,
    output word_t         wb_data_o
);

    word_t regs [`CORE_REG_COUNT];
    logic  wr_en;
    logic  wt_rs;
    logic  wt_rt;

    assign wr_en = res_i.valid && (res_i.dest != '0);

    ////////////////////
    // Register file

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_i.dest] <= res_i.data;
        end
    end

    // Write-through for the instruction two ahead
    assign wt_rs = wr_en && (res_i.dest == rd_port.rs_addr);
    assign wt_rt = wr_en && (res_i.dest == rd_port.rt_addr);

    assign rd_port.rs_data = (rd_port.rs_addr == '0) ? '0 :
                             wt_rs ? res_i.data : regs[rd_port.rs_addr];
    assign rd_port.rt_data = (rd_port.rt_addr == '0) ? '0 :
                             wt_rt ? res_i.data : regs[rd_port.rt_addr];

    ////////////////////
    // Write-back port

    // Register 0 writes still show here
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= res_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= res_i.dest;
        wb_data_o <= res_i.data;
    end

endmodule

`default_nettype wire

/* logic/mips_core.sv */
`default_nettype none

module mips_core import core_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      instr_valid_i,
    input  instr_u    instr_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    dec_exe_if  dec_exe ();
    exe_res_if  exe_res ();
    reg_read_if reg_read ();

    // Decode and operand read
    decode_stage i_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rd_port       (reg_read.requester),
        .dec_o         (dec_exe.source)
    );

    // Forwarding, ALU, shifter
    execute_stage i_execute (
        .clk     (clk),
        .reset_i (reset_i),
        .dec_i   (dec_exe.sink),
        .res_o   (exe_res.source)
    );

    // Register file and write-back
    result_stage i_result (
        .clk        (clk),
        .reset_i    (reset_i),
        .res_i      (exe_res.sink),
        .rd_port    (reg_read.responder),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* verification/mips_core_properties.sv */
`default_nettype none

`include "core_settings.svh"

module mips_core_properties import core_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input logic      instr_valid_i,
    input logic      wb_valid_i,
    input reg_addr_t wb_addr_i,
    input word_t     r0_data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // Reset

    assert property (@(posedge clk) reset_i |=> !wb_valid_i)
        else $error("wb_valid_o high in the cycle after reset");

    ////////////////////
    // Register 0

    // Stored word, not the hardwired read path
    assert property (@(posedge clk) disable iff (reset_i)
        (wb_valid_i && (wb_addr_i == '0)) |=> (r0_data_i == '0))
        else $error("register 0 holds a nonzero word after a write-back to it");

    ////////////////////
    // Latency

    assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_i |-> $past(instr_valid_i, `CORE_LATENCY))
        else $error("write-back without an instruction CORE_LATENCY cycles earlier");

endmodule

bind mips_core mips_core_properties i_mips_core_properties (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_addr_i     (wb_addr_o),
    .r0_data_i     (i_result.regs[0])
);

`default_nettype wire

/* verification/mips_core_tb.sv */
`default_nettype none

`include "core_settings.svh"

module mips_core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // 4 reset + 22 directed + 200 random with gaps + drain plus margin
    localparam int TIMEOUT_CYCLES = 400;

    logic      clk;
    logic      reset_i;
    logic      instr_valid_i;
    instr_u    instr_i;
    logic      wb_valid_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    int        seed = 46;
    int        cycle = 0;
    int        data_errors = 0;
    int        latency_errors = 0;
    int        other_errors = 0;

    word_t     model_regs [`CORE_REG_COUNT];
    reg_addr_t exp_addr_q [$];
    word_t     exp_data_q [$];
    int        exp_cycle_q [$];

    mips_core i_mips_core (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // Instruction builders

    function automatic instr_u r_instr(input logic [5:0] funct, input reg_addr_t rd,
                                       input reg_addr_t rs, input reg_addr_t rt,
                                       input logic [4:0] shamt);
        instr_u w;
        w         = '0;
        w.r.funct = funct;
        w.r.rd    = rd;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.shamt = shamt;
        return w;
    endfunction

    function automatic instr_u i_instr(input logic [5:0] opcode, input reg_addr_t rt,
                                       input reg_addr_t rs, input logic [15:0] imm);
        instr_u w;
        w          = '0;
        w.i.opcode = opcode;
        w.i.rt     = rt;
        w.i.rs     = rs;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic reg_addr_t pick_reg();
        word_t rnd;
        rnd = $random(seed);
        // Mostly a small set so that dependencies are frequent
        if (rnd[7:5] == 3'd0) return rnd[4:0];
        return {2'b00, rnd[2:0]};
    endfunction

    function automatic instr_u random_instr();
        word_t      rnd;
        logic [3:0] kind;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        rnd  = $random(seed);
        kind = rnd[31:28];
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        case (kind)
            4'd0:  return r_instr(`CORE_FN_ADDU, rd, rs, rt, 5'd0);
            4'd1:  return r_instr(`CORE_FN_SUBU, rd, rs, rt, 5'd0);
            4'd2:  return r_instr(`CORE_FN_AND, rd, rs, rt, 5'd0);
            4'd3:  return r_instr(`CORE_FN_OR, rd, rs, rt, 5'd0);
            4'd4:  return r_instr(`CORE_FN_XOR, rd, rs, rt, 5'd0);
            4'd5:  return r_instr(`CORE_FN_SLT, rd, rs, rt, 5'd0);
            4'd6:  return r_instr(`CORE_FN_SLL, rd, rs, rt, rnd[20:16]);
            4'd7:  return r_instr(`CORE_FN_SRL, rd, rs, rt, rnd[20:16]);
            4'd8:  return r_instr(`CORE_FN_SRA, rd, rs, rt, rnd[20:16]);
            4'd9:  return r_instr(`CORE_FN_SLLV, rd, rs, rt, 5'd0);
            4'd10: return i_instr(`CORE_OP_ADDIU, rt, rs, rnd[15:0]);
            4'd11: return i_instr(`CORE_OP_ANDI, rt, rs, rnd[15:0]);
            4'd12: return i_instr(`CORE_OP_ORI, rt, rs, rnd[15:0]);
            4'd13: return i_instr(`CORE_OP_LUI, rt, rs, rnd[15:0]);
            4'd14: return r_instr(`CORE_FN_SRA, rd, rs, rt, rnd[20:16]);
            default: begin
                // Unsupported load opcode or MULT
                if (rnd[27]) return i_instr(6'h23, rt, rs, rnd[15:0]);
                return r_instr(6'h18, rd, rs, rt, 5'd0);
            end
        endcase
    endfunction

    ////////////////////
    // Reference model

    function automatic bit model_exec(input instr_u w, output reg_addr_t dest,
                                      output word_t val);
        word_t rs_v;
        word_t rt_v;
        bit    ok;
        ok   = 1'b1;
        rs_v = model_regs[w.r.rs];
        rt_v = model_regs[w.r.rt];
        dest = w.r.rd;
        val  = '0;
        if (w.r.opcode == `CORE_OP_RTYPE) begin
            case (w.r.funct)
                `CORE_FN_ADDU: val = rs_v + rt_v;
                `CORE_FN_SUBU: val = rs_v - rt_v;
                `CORE_FN_AND:  val = rs_v & rt_v;
                `CORE_FN_OR:   val = rs_v | rt_v;
                `CORE_FN_XOR:  val = rs_v ^ rt_v;
                // Differing signs decide on their own
                `CORE_FN_SLT:  val = (rs_v[31] != rt_v[31]) ? {31'd0, rs_v[31]} :
                                                              {31'd0, rs_v < rt_v};
                `CORE_FN_SLL:  val = rt_v << w.r.shamt;
                `CORE_FN_SRL:  val = rt_v >> w.r.shamt;
                `CORE_FN_SRA:  val = (rt_v >> w.r.shamt) |
                                     (rt_v[31] ? ~(32'hffff_ffff >> w.r.shamt) : 32'd0);
                `CORE_FN_SLLV: val = rt_v << rs_v[4:0];
                default:       ok = 1'b0;
            endcase
        end else begin
            dest = w.i.rt;
            case (w.i.opcode)
                `CORE_OP_ADDIU: val = rs_v + {{16{w.i.imm[15]}}, w.i.imm};
                `CORE_OP_ANDI:  val = rs_v & {16'h0000, w.i.imm};
                `CORE_OP_ORI:   val = rs_v | {16'h0000, w.i.imm};
                `CORE_OP_LUI:   val = {w.i.imm, 16'h0000};
                default:        ok = 1'b0;
            endcase
        end
        return ok;
    endfunction

    ////////////////////
    // Checking and driving

    task automatic check_writeback();
        reg_addr_t exp_addr;
        word_t     exp_data;
        int        issued;
        if (wb_valid_o) begin
            assert (exp_addr_q.size() > 0) else begin
                $display("Write-back at %0d ns with no instruction outstanding", $time);
                other_errors++;
            end
            if (exp_addr_q.size() > 0) begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                issued   = exp_cycle_q.pop_front();
                assert (wb_addr_o == exp_addr) else begin
                    $display("Error at %0d ns wb_addr_o expected %0d actual %0d",
                             $time, exp_addr, wb_addr_o);
                    data_errors++;
                end
                assert (wb_data_o == exp_data) else begin
                    $display("Error at %0d ns wb_data_o expected %08h actual %08h",
                             $time, exp_data, wb_data_o);
                    data_errors++;
                end
                assert (cycle - issued == `CORE_LATENCY) else begin
                    $display("Write-back at %0d ns came %0d cycles after its instruction",
                             $time, cycle - issued);
                    latency_errors++;
                end
            end
        end else if (exp_cycle_q.size() > 0 && cycle - exp_cycle_q[0] >= `CORE_LATENCY) begin
            assert (1'b0) else begin
                $display("Write-back for register %0d missing at %0d ns",
                         exp_addr_q[0], $time);
                latency_errors++;
            end
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_cycle_q.pop_front());
        end
    endtask

    task automatic step(input bit valid, input instr_u w);
        reg_addr_t dest;
        word_t     val;
        bit        ok;
        @(negedge clk);
        check_writeback();
        instr_valid_i = valid;
        instr_i       = w;
        ok            = 1'b0;
        if (valid) ok = model_exec(w, dest, val);
        if (ok) begin
            exp_addr_q.push_back(dest);
            exp_data_q.push_back(val);
            exp_cycle_q.push_back(cycle);
            if (dest != '0) model_regs[dest] = val;
        end
    endtask

    ////////////////////
    // Stimulus

    initial begin
        instr_u w;
        word_t  rnd;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < `CORE_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(negedge clk);
        reset_i = 1'b0;

        // Registers read zero after reset
        step(1'b0, '0);
        step(1'b1, r_instr(`CORE_FN_OR, 5'd1, 5'd0, 5'd0, 5'd0));
        step(1'b1, r_instr(`CORE_FN_OR, 5'd2, 5'd3, 5'd31, 5'd0));
        step(1'b1, r_instr(`CORE_FN_OR, 5'd3, 5'd17, 5'd0, 5'd0));
        // Immediates with sign and zero extension
        step(1'b1, i_instr(`CORE_OP_ADDIU, 5'd1, 5'd0, 16'hfffb));
        step(1'b1, i_instr(`CORE_OP_ORI, 5'd2, 5'd0, 16'h8001));
        step(1'b1, i_instr(`CORE_OP_ANDI, 5'd3, 5'd1, 16'h8ff0));
        step(1'b1, i_instr(`CORE_OP_LUI, 5'd4, 5'd0, 16'h8765));
        // ALU and shifts with dependencies at distance one and two
        step(1'b1, r_instr(`CORE_FN_SLT, 5'd5, 5'd1, 5'd2, 5'd0));
        step(1'b1, r_instr(`CORE_FN_SLT, 5'd6, 5'd2, 5'd1, 5'd0));
        step(1'b1, r_instr(`CORE_FN_SRA, 5'd7, 5'd0, 5'd4, 5'd4));
        step(1'b1, r_instr(`CORE_FN_SRL, 5'd8, 5'd0, 5'd7, 5'd8));
        step(1'b1, r_instr(`CORE_FN_SLLV, 5'd9, 5'd1, 5'd2, 5'd0));
        step(1'b1, r_instr(`CORE_FN_ADDU, 5'd10, 5'd9, 5'd9, 5'd0));
        step(1'b1, r_instr(`CORE_FN_SUBU, 5'd11, 5'd10, 5'd1, 5'd0));
        step(1'b1, r_instr(`CORE_FN_XOR, 5'd12, 5'd11, 5'd10, 5'd0));
        step(1'b1, r_instr(`CORE_FN_AND, 5'd13, 5'd12, 5'd3, 5'd0));
        // Register 0 is written on the port but stays zero
        step(1'b1, i_instr(`CORE_OP_ADDIU, 5'd0, 5'd1, 16'h0007));
        step(1'b1, r_instr(`CORE_FN_OR, 5'd14, 5'd0, 5'd0, 5'd0));
        step(1'b1, r_instr(`CORE_FN_ADDU, 5'd15, 5'd0, 5'd14, 5'd0));
        // Unsupported opcodes produce no write-back
        step(1'b1, i_instr(6'h23, 5'd16, 5'd1, 16'h0004));
        step(1'b1, r_instr(6'h18, 5'd17, 5'd1, 5'd2, 5'd0));
        step(1'b1, r_instr(`CORE_FN_SLL, 5'd18, 5'd0, 5'd2, 5'd31));

        for (int n = 0; n < 200; n++) begin
            w = random_instr();
            step(1'b1, w);
            rnd = $random(seed);
            if (rnd[3:0] == 4'h0) step(1'b0, '0);
        end

        repeat (`CORE_LATENCY + 2) step(1'b0, '0);

        assert (exp_addr_q.size() == 0) else begin
            $display("%0d expected write-backs never arrived", exp_addr_q.size());
            other_errors++;
        end
        $display("Errors: data %0d, latency %0d, other %0d",
                 data_errors, latency_errors, other_errors);
        if (data_errors + latency_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/core_pkg.sv
logic/core_ifs.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_core.sv
verification/mips_core_properties.sv
verification/mips_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mips_core_tb -f project.f -o mips_core_sim \
    && ./obj_dir/mips_core_sim | tee /dev/stderr | grep -q "=== PASS ===" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
